// File: dptx_pkg.sv
// DisplayPort TX link package
// Message IDs, state and pattern enums, symbol codes and scrambler seed
// shared by the link layer modules

`default_nettype none

package dptx_pkg;

    // Message port
    localparam int MSG_DAT_W = 16;                  // Message word width

    typedef enum logic [7:0] {
        MSG_ID_CTL = 8'h10,                         // Lane count and scrambler enable
        MSG_ID_TPS = 8'h11                          // Training pattern select
    } msg_id_e;

    // Training pattern select
    typedef enum logic [1:0] {
        TPS_NONE = 2'd0,
        TPS1     = 2'd1,
        TPS2     = 2'd2
    } tps_e;

    // Active lane codes, zero is not a legal code
    typedef enum logic [1:0] {
        LANES_1 = 2'd1,
        LANES_2 = 2'd2,
        LANES_4 = 2'd3
    } act_lanes_e;

    typedef enum logic [1:0] {
        DEC_IDLE,                                   // Waiting for start of message
        DEC_CTL,
        DEC_TPS,
        DEC_SKIP                                    // Unknown ID, drop until eom
    } dec_state_e;

    // Symbols
    localparam int SYM_W = 8;
    localparam logic [SYM_W-1:0] SYM_D10_2 = 8'h4A; // TPS1 and TPS2 filler
    localparam logic [SYM_W-1:0] SYM_K28_5 = 8'hBC; // Comma
    localparam logic [SYM_W-1:0] SYM_D11_6 = 8'hCB;
    localparam logic [SYM_W-1:0] SYM_SR    = 8'h1C; // K28.0 scrambler reset

    // Scrambler and training
    localparam logic [15:0] SCRM_SEED = 16'hFFFF;
    localparam int TPS2_LEN = 10;                   // TPS2 sequence length in symbols

endpackage

`default_nettype wire

// File: dptx_msg_dec.sv
// DisplayPort TX message decoder
// Takes two-word messages from the message port and holds the
// link configuration: active lane count, scrambler enable and
// training pattern select. Unknown IDs are skipped until eom.

`timescale 1ns/1ns
`default_nettype none

module dptx_msg_dec
    import dptx_pkg::*;
(
    input  logic                    lnk_clk,
    input  logic                    rst_n,

    // Message port
    input  logic                    msg_vld,
    input  logic                    msg_som,
    input  logic                    msg_eom,
    input  logic [MSG_DAT_W-1:0]    msg_dat,

    // Configuration
    output act_lanes_e              cfg_lanes,
    output logic                    cfg_scrm_en,
    output tps_e                    cfg_tps
);

    dec_state_e state;

    always_ff @(posedge lnk_clk)
    begin
        if (!rst_n)
        begin
            state       <= DEC_IDLE;
            cfg_lanes   <= LANES_1;             // Single lane after reset
            cfg_scrm_en <= 1'b0;
            cfg_tps     <= TPS_NONE;
        end
        else if (msg_vld)
        begin
            case (state)
                DEC_IDLE :
                begin
                    if (msg_som)
                    begin
                        // ID sits in the low byte
                        if (msg_dat[7:0] == MSG_ID_CTL)
                            state <= DEC_CTL;
                        else if (msg_dat[7:0] == MSG_ID_TPS)
                            state <= DEC_TPS;
                        else
                            state <= DEC_SKIP;
                    end
                end

                DEC_CTL :
                begin
                    if (msg_dat[1:0] != 2'd0)   // Code 0 is illegal, keep old count
                        cfg_lanes <= act_lanes_e'(msg_dat[1:0]);
                    cfg_scrm_en <= msg_dat[2];
                    if (msg_eom)
                        state <= DEC_IDLE;
                end

                DEC_TPS :
                begin
                    case (msg_dat[1:0])
                        2'd1    : cfg_tps <= TPS1;
                        2'd2    : cfg_tps <= TPS2;
                        default : cfg_tps <= TPS_NONE; // Reserved code falls back to main link
                    endcase
                    if (msg_eom)
                        state <= DEC_IDLE;
                end

                default :                       // DEC_SKIP
                begin
                    if (msg_eom)
                        state <= DEC_IDLE;
                end
            endcase
        end
    end

    // Framing flags only travel with a valid word
    a_flag_vld : assert property (@(posedge lnk_clk) disable iff (!rst_n)
        (msg_som || msg_eom) |-> msg_vld);

    // Sender never starts a new message before the last one ended
    a_som_idle : assert property (@(posedge lnk_clk) disable iff (!rst_n)
        (msg_vld && msg_som) |-> (state == DEC_IDLE));

endmodule

`default_nettype wire

// File: dptx_scrm.sv
// DisplayPort TX scrambler, one lane
// 16-bit LFSR x^16+x^5+x^4+x^3+1, SPL symbols per clock in time order.
// A K28.0 SR symbol reloads the seed, other K symbols pass unscrambled
// but still advance the LFSR. One clock of latency.

`timescale 1ns/1ns
`default_nettype none

module dptx_scrm
    import dptx_pkg::*;
#(
    parameter int SPL = 2                           // Symbols per lane per clock
)
(
    input  logic                    lnk_clk,
    input  logic                    rst_n,
    input  logic                    en,             // Scrambler enable
    input  logic                    in_vld,
    input  logic [SPL*SYM_W-1:0]    in_dat,
    input  logic [SPL-1:0]          in_k,
    output logic [SPL*SYM_W-1:0]    out_dat,
    output logic [SPL-1:0]          out_k
);

    logic [15:0]            lfsr;
    logic [15:0]            lfsr_nxt;
    logic [SYM_W-1:0]       sym;                    // Symbol being worked on
    logic [SPL*SYM_W-1:0]   dat_nxt;

    // One LFSR step, bit 15 feeds back into taps 0, 3, 4 and 5
    function automatic logic [15:0] lfsr_step(input logic [15:0] l);
        lfsr_step = {l[14:0], l[15]};
        lfsr_step[3] = l[2] ^ l[15];
        lfsr_step[4] = l[3] ^ l[15];
        lfsr_step[5] = l[4] ^ l[15];
    endfunction

    always_comb
    begin
        lfsr_nxt = lfsr;
        dat_nxt  = '0;
        sym      = '0;
        for (int s = 0; s < SPL; s++)
        begin
            sym = in_dat[s*SYM_W +: SYM_W];
            if (in_k[s] && (sym == SYM_SR))
                lfsr_nxt = SCRM_SEED;               // Reseed after the SR itself
            else
            begin
                for (int n = 0; n < SYM_W; n++)
                begin
                    if (en && !in_k[s])             // Data only
                        sym[n] = sym[n] ^ lfsr_nxt[15];
                    lfsr_nxt = lfsr_step(lfsr_nxt);
                end
            end
            dat_nxt[s*SYM_W +: SYM_W] = sym;
        end
    end

    always_ff @(posedge lnk_clk)
    begin
        if (!rst_n)
        begin
            lfsr    <= SCRM_SEED;
            out_dat <= '0;
            out_k   <= '0;
        end
        else
        begin
            lfsr    <= lfsr_nxt;                    // Runs on idle beats too
            out_dat <= in_vld ? dat_nxt : '0;       // Idle beat stays zero
            out_k   <= in_vld ? in_k : '0;
        end
    end

    // All-zero state would lock the LFSR
    a_lfsr_live : assert property (@(posedge lnk_clk) disable iff (!rst_n)
        lfsr != 16'h0000);

endmodule

`default_nettype wire

// File: dptx_trn.sv
// DisplayPort TX training pattern generator
// Passes the scrambled main link, or replaces it on all lanes with TPS1
// (D10.2) or the 10-symbol TPS2 sequence. The TPS2 phase is shared by
// all lanes and restarts whenever TPS2 is freshly selected.

`timescale 1ns/1ns
`default_nettype none

module dptx_trn
    import dptx_pkg::*;
#(
    parameter int LANES = 4,
    parameter int SPL   = 2
)
(
    input  logic                        lnk_clk,
    input  logic                        rst_n,
    input  tps_e                        tps,        // Pattern select
    input  logic [LANES*SPL*SYM_W-1:0]  in_dat,     // From scramblers
    input  logic [LANES*SPL-1:0]        in_k,
    output logic [LANES*SPL*SYM_W-1:0]  out_dat,
    output logic [LANES*SPL-1:0]        out_k
);

    logic [3:0]             phase;                  // TPS2 position of symbol 0
    logic [3:0]             phase_nxt;
    logic [3:0]             idx;
    logic [SPL*SYM_W-1:0]   tps2_dat;               // One lane worth of TPS2
    logic [SPL-1:0]         tps2_k;

    // K28.5 D11.6 K28.5 D11.6 then six D10.2, K flag on K28.5 only
    function automatic logic [SYM_W:0] tps2_sym(input logic [3:0] i);
        case (i)
            4'd0, 4'd2 : tps2_sym = {1'b1, SYM_K28_5};
            4'd1, 4'd3 : tps2_sym = {1'b0, SYM_D11_6};
            default    : tps2_sym = {1'b0, SYM_D10_2};
        endcase
    endfunction

    always_comb
    begin
        tps2_dat = '0;
        tps2_k   = '0;
        idx      = '0;
        for (int s = 0; s < SPL; s++)
        begin
            idx = phase + 4'(s);
            if (idx >= 4'(TPS2_LEN))                // Wrap within this beat
                idx = idx - 4'(TPS2_LEN);
            {tps2_k[s], tps2_dat[s*SYM_W +: SYM_W]} = tps2_sym(idx);
        end
        phase_nxt = phase + 4'(SPL);
        if (phase_nxt >= 4'(TPS2_LEN))
            phase_nxt = phase_nxt - 4'(TPS2_LEN);
    end

    always_ff @(posedge lnk_clk)
    begin
        if (!rst_n)
        begin
            phase   <= '0;
            out_dat <= '0;
            out_k   <= '0;
        end
        else
        begin
            case (tps)
                TPS1 :
                begin
                    out_dat <= {(LANES*SPL){SYM_D10_2}};
                    out_k   <= '0;
                    phase   <= '0;
                end
                TPS2 :
                begin
                    out_dat <= {LANES{tps2_dat}};   // Same pattern on every lane
                    out_k   <= {LANES{tps2_k}};
                    phase   <= phase_nxt;
                end
                default :                           // Main link
                begin
                    out_dat <= in_dat;
                    out_k   <= in_k;
                    phase   <= '0;                  // Next TPS2 starts at K28.5
                end
            endcase
        end
    end

endmodule

`default_nettype wire

// File: dptx_skew.sv
// DisplayPort TX lane skew
// Delays one lane by LANE clocks and blanks it when the lane
// is outside the active lane count

`timescale 1ns/1ns
`default_nettype none

module dptx_skew
    import dptx_pkg::*;
#(
    parameter int LANE = 0,                         // Lane index, also the delay
    parameter int SPL  = 2
)
(
    input  logic                    lnk_clk,
    input  logic                    rst_n,
    input  act_lanes_e              lanes,          // Active lane count
    input  logic [SPL*SYM_W-1:0]    in_dat,
    input  logic [SPL-1:0]          in_k,
    output logic [SPL*SYM_W-1:0]    out_dat,
    output logic [SPL-1:0]          out_k
);

    logic [SPL*SYM_W-1:0]   dly_dat;
    logic [SPL-1:0]         dly_k;
    logic                   lane_act;

    generate
        if (LANE == 0)
        begin : gen_direct
            assign dly_dat = in_dat;                // Lane 0 has no skew
            assign dly_k   = in_k;
        end
        else
        begin : gen_chain
            logic [SPL*SYM_W-1:0]   dat_q [LANE];
            logic [SPL-1:0]         k_q   [LANE];

            always_ff @(posedge lnk_clk)
            begin
                if (!rst_n)
                begin
                    for (int d = 0; d < LANE; d++)
                    begin
                        dat_q[d] <= '0;
                        k_q[d]   <= '0;
                    end
                end
                else
                begin
                    dat_q[0] <= in_dat;
                    k_q[0]   <= in_k;
                    for (int d = 1; d < LANE; d++)
                    begin
                        dat_q[d] <= dat_q[d-1];
                        k_q[d]   <= k_q[d-1];
                    end
                end
            end

            assign dly_dat = dat_q[LANE-1];
            assign dly_k   = k_q[LANE-1];
        end
    endgenerate

    // Lane count codes map to 1, 2 and 4 lanes
    always_comb
    begin
        case (lanes)
            LANES_4 : lane_act = (LANE < 4);
            LANES_2 : lane_act = (LANE < 2);
            default : lane_act = (LANE < 1);
        endcase
    end

    assign out_dat = lane_act ? dly_dat : '0;       // Idle lanes drive zero
    assign out_k   = lane_act ? dly_k : '0;

endmodule

`default_nettype wire

// File: dptx_lnk.sv
// DisplayPort TX link layer, single stream
// Input register, message decoder, per-lane scramblers, training
// pattern generator and per-lane skew. Lane l symbol s sits at flat
// index l*SPL+s. Lane i latency is 3+i clocks.

`timescale 1ns/1ns
`default_nettype none

module dptx_lnk
    import dptx_pkg::*;
#(
    parameter int LANES = 4,                        // 1, 2 or 4
    parameter int SPL   = 2                         // Symbols per lane per clock
)
(
    input  logic                        lnk_clk,
    input  logic                        rst_n,

    // Message port
    input  logic                        msg_vld,
    input  logic                        msg_som,
    input  logic                        msg_eom,
    input  logic [MSG_DAT_W-1:0]        msg_dat,

    // Link input
    input  logic                        src_vld,
    input  logic [LANES*SPL*SYM_W-1:0]  src_dat,
    input  logic [LANES*SPL-1:0]        src_k,

    // Link output to PHY
    output logic [LANES*SPL*SYM_W-1:0]  lnk_dat,
    output logic [LANES*SPL-1:0]        lnk_k
);

    localparam int LW = SPL*SYM_W;                  // Bits per lane

    act_lanes_e                     cfg_lanes;
    logic                           cfg_scrm_en;
    tps_e                           cfg_tps;

    logic                           src_vld_q;
    logic [LANES*SPL*SYM_W-1:0]     src_dat_q;
    logic [LANES*SPL-1:0]           src_k_q;
    logic [LANES*SPL*SYM_W-1:0]     scrm_dat;
    logic [LANES*SPL-1:0]           scrm_k;
    logic [LANES*SPL*SYM_W-1:0]     trn_dat;
    logic [LANES*SPL-1:0]           trn_k;

    // Input register, idle beats read as zero data with K clear
    always_ff @(posedge lnk_clk)
    begin
        if (!rst_n)
        begin
            src_vld_q <= 1'b0;
            src_dat_q <= '0;
            src_k_q   <= '0;
        end
        else
        begin
            src_vld_q <= src_vld;
            src_dat_q <= src_vld ? src_dat : '0;
            src_k_q   <= src_vld ? src_k : '0;
        end
    end

    dptx_msg_dec dec_i
    (
        .lnk_clk     (lnk_clk),
        .rst_n       (rst_n),
        .msg_vld     (msg_vld),
        .msg_som     (msg_som),
        .msg_eom     (msg_eom),
        .msg_dat     (msg_dat),
        .cfg_lanes   (cfg_lanes),
        .cfg_scrm_en (cfg_scrm_en),
        .cfg_tps     (cfg_tps)
    );

    // One scrambler per lane
    for (genvar l = 0; l < LANES; l++)
    begin : gen_scrm
        dptx_scrm #(.SPL (SPL)) scrm_i
        (
            .lnk_clk (lnk_clk),
            .rst_n   (rst_n),
            .en      (cfg_scrm_en),
            .in_vld  (src_vld_q),
            .in_dat  (src_dat_q[l*LW +: LW]),
            .in_k    (src_k_q[l*SPL +: SPL]),
            .out_dat (scrm_dat[l*LW +: LW]),
            .out_k   (scrm_k[l*SPL +: SPL])
        );
    end

    dptx_trn #(.LANES (LANES), .SPL (SPL)) trn_i
    (
        .lnk_clk (lnk_clk),
        .rst_n   (rst_n),
        .tps     (cfg_tps),
        .in_dat  (scrm_dat),
        .in_k    (scrm_k),
        .out_dat (trn_dat),
        .out_k   (trn_k)
    );

    // Lane i delayed by i clocks, inactive lanes blanked
    for (genvar l = 0; l < LANES; l++)
    begin : gen_skew
        dptx_skew #(.LANE (l), .SPL (SPL)) skew_i
        (
            .lnk_clk (lnk_clk),
            .rst_n   (rst_n),
            .lanes   (cfg_lanes),
            .in_dat  (trn_dat[l*LW +: LW]),
            .in_k    (trn_k[l*SPL +: SPL]),
            .out_dat (lnk_dat[l*LW +: LW]),
            .out_k   (lnk_k[l*SPL +: SPL])
        );
    end

endmodule

`default_nettype wire

// File: tb_dptx_model.svh
// Reference models and typed compare tasks for the DP TX link testbench
// Per-lane scrambler model, TPS2 sequence table, checks on symbols,
// training pattern and lane count. Included inside the testbench module.

`ifndef TB_DPTX_MODEL_SVH
`define TB_DPTX_MODEL_SVH

// Scramble one symbol of one lane and step that lane's model LFSR
function automatic logic [SYM_W-1:0] scramble_sym(input int lane,
                                                  input logic [SYM_W-1:0] d,
                                                  input logic k,
                                                  input logic en);
    logic [SYM_W-1:0] q;
    logic             fb;
    q = d;
    if (k && d == SYM_SR)
    begin
        model_lfsr[lane] = SCRM_SEED;               // Seed again after the SR
        return q;
    end
    for (int n = 0; n < SYM_W; n++)
    begin
        fb = model_lfsr[lane][15];
        if (en && !k)
            q[n] = d[n] ^ fb;                       // Data bit n uses bit 15 before step n
        // Shift up and fold bit 15 back in at x^5, x^4, x^3 and 1
        model_lfsr[lane] = {model_lfsr[lane][14:0], 1'b0} ^ (fb ? 16'h0039 : 16'h0000);
    end
    return q;
endfunction

// TPS2 symbol with its K flag at a position in the sequence
function automatic logic [SYM_W:0] tps2_expected(input int pos);
    logic [SYM_W:0] seq [TPS2_LEN];
    seq = '{
        {1'b1, SYM_K28_5},
        {1'b0, SYM_D11_6},
        {1'b1, SYM_K28_5},
        {1'b0, SYM_D11_6},
        {1'b0, SYM_D10_2},                          // Six fillers
        {1'b0, SYM_D10_2},
        {1'b0, SYM_D10_2},
        {1'b0, SYM_D10_2},
        {1'b0, SYM_D10_2},
        {1'b0, SYM_D10_2}
    };
    return seq[pos % TPS2_LEN];
endfunction

task automatic compare_sym(input string name, input int lane, input int sym,
                           input logic [SYM_W-1:0] exp_dat, input logic exp_k,
                           input logic [SYM_W-1:0] act_dat, input logic act_k);
    if (act_dat !== exp_dat || act_k !== exp_k)
    begin
        $display("ERROR %s lane %0d sym %0d expected %02h k=%0b actual %02h k=%0b",
                 name, lane, sym, exp_dat, exp_k, act_dat, act_k);
        test_errs++;
    end
endtask

task automatic compare_tps(input string name, input tps_e exp_tps, input tps_e act_tps);
    if (act_tps !== exp_tps)
    begin
        $display("ERROR %s cfg_tps expected %0d actual %0d", name, exp_tps, act_tps);
        test_errs++;
    end
endtask

task automatic compare_lanes(input string name, input act_lanes_e exp_lanes,
                             input act_lanes_e act_lanes);
    if (act_lanes !== exp_lanes)
    begin
        $display("ERROR %s cfg_lanes expected %0d actual %0d", name, exp_lanes, act_lanes);
        test_errs++;
    end
endtask

`endif

// File: tb_dptx_lnk.sv
// Directed testbench for the DisplayPort TX link layer
// Drives the message port and link input of a 4-lane, 2-symbol DUT and
// checks reset state, skew, scrambling, TPS1, TPS2 and lane gating

`timescale 1ns/1ns

module tb_dptx_lnk
    import dptx_pkg::*;
();

    localparam int LANES    = 4;
    localparam int SPL      = 2;
    localparam int NSYM     = LANES*SPL;            // Symbols per beat
    localparam int BEATS    = 32;                   // Beats per data test
    localparam int PIPE     = 3 + LANES;            // Worst lane latency
    localparam int COLLECT  = PIPE + 20;            // TPS2 capture, cycles
    localparam int TEST_CYC = BEATS + 3*PIPE + 30;  // Budget for one test
    localparam int WD_CYC   = 10 + 6*TEST_CYC + 100;

    logic                   lnk_clk = 1'b0;
    logic                   rst_n;
    logic                   msg_vld;
    logic                   msg_som;
    logic                   msg_eom;
    logic [MSG_DAT_W-1:0]   msg_dat;
    logic                   src_vld;
    logic [NSYM*SYM_W-1:0]  src_dat;
    logic [NSYM-1:0]        src_k;
    logic [NSYM*SYM_W-1:0]  lnk_dat;
    logic [NSYM-1:0]        lnk_k;

    logic [NSYM*SYM_W-1:0]  beat_dat [BEATS];       // Stimulus
    logic [NSYM-1:0]        beat_k   [BEATS];
    logic [NSYM*SYM_W-1:0]  exp_dat  [BEATS];       // Expected lane data per beat
    logic [NSYM-1:0]        exp_k    [BEATS];
    logic [15:0]            model_lfsr [LANES];
    int                     test_errs = 0;
    int                     err_total = 0;
    int                     tests_run = 0;
    int                     tests_failed = 0;

    `include "tb_dptx_model.svh"

    always #20 lnk_clk = ~lnk_clk;                  // 40 ns period

    dptx_lnk #(.LANES (LANES), .SPL (SPL)) dptx_lnk_i
    (
        .lnk_clk (lnk_clk),
        .rst_n   (rst_n),
        .msg_vld (msg_vld),
        .msg_som (msg_som),
        .msg_eom (msg_eom),
        .msg_dat (msg_dat),
        .src_vld (src_vld),
        .src_dat (src_dat),
        .src_k   (src_k),
        .lnk_dat (lnk_dat),
        .lnk_k   (lnk_k)
    );

    task automatic wait_cycles(input int n);
        repeat (n) @(posedge lnk_clk);
    endtask

    // ID word then value word, eom word taken on the returning edge
    task automatic send_msg(input logic [7:0] id, input logic [7:0] val);
        @(posedge lnk_clk);
        msg_vld <= 1'b1;
        msg_som <= 1'b1;
        msg_eom <= 1'b0;
        msg_dat <= {8'h00, id};
        @(posedge lnk_clk);
        msg_som <= 1'b0;
        msg_eom <= 1'b1;
        msg_dat <= {8'h00, val};
        @(posedge lnk_clk);
        msg_vld <= 1'b0;
        msg_eom <= 1'b0;
        msg_dat <= '0;
    endtask

    function automatic logic [NSYM*SYM_W-1:0] rand_bus();
        logic [NSYM*SYM_W-1:0] v;
        for (int i = 0; i < NSYM; i++)
            v[i*SYM_W +: SYM_W] = 8'($urandom);
        return v;
    endfunction

    // Random beats, with_k sprinkles K28.5 symbols; expected defaults to input
    task automatic make_beats(input bit with_k);
        for (int b = 0; b < BEATS; b++)
        begin
            beat_dat[b] = rand_bus();
            beat_k[b]   = '0;
            for (int i = 0; i < NSYM; i++)
            begin
                if (with_k && ($urandom % 8) == 0)
                begin
                    beat_dat[b][i*SYM_W +: SYM_W] = SYM_K28_5;
                    beat_k[b][i] = 1'b1;
                end
            end
            exp_dat[b] = beat_dat[b];
            exp_k[b]   = beat_k[b];
        end
    endtask

    // Beat driven at edge N shows on lane l after edge N+3+l
    task automatic run_beats(input string name, input int active);
        int b;
        int i;
        for (int t = 0; t < BEATS + PIPE; t++)
        begin
            @(posedge lnk_clk);
            src_vld <= (t < BEATS);
            src_dat <= (t < BEATS) ? beat_dat[t] : '0;
            src_k   <= (t < BEATS) ? beat_k[t] : '0;
            @(negedge lnk_clk);
            for (int l = 0; l < LANES; l++)
            begin
                b = t - 3 - l;
                for (int s = 0; s < SPL; s++)
                begin
                    i = l*SPL + s;
                    if (l >= active)                // Idle lanes stay zero
                        compare_sym(name, l, s, '0, 1'b0, lnk_dat[i*SYM_W +: SYM_W], lnk_k[i]);
                    else if (b >= 0 && b < BEATS)
                        compare_sym(name, l, s, exp_dat[b][i*SYM_W +: SYM_W], exp_k[b][i],
                                    lnk_dat[i*SYM_W +: SYM_W], lnk_k[i]);
                end
            end
        end
    endtask

    task automatic finish_test(input string name);
        tests_run++;
        if (test_errs == 0)
            $display("test %s ok", name);
        else
        begin
            $display("test %s failed with %0d mismatches", name, test_errs);
            tests_failed++;
        end
        err_total += test_errs;
        test_errs = 0;
    endtask

    task automatic test_reset();
        for (int c = 0; c < 2*PIPE; c++)
        begin
            @(posedge lnk_clk);
            src_vld <= 1'b0;                        // Junk on the bus, valid low
            src_dat <= rand_bus();
            src_k   <= NSYM'($urandom);
            @(negedge lnk_clk);
            for (int i = 0; i < NSYM; i++)
                compare_sym("reset", i / SPL, i % SPL, '0, 1'b0,
                            lnk_dat[i*SYM_W +: SYM_W], lnk_k[i]);
        end
        compare_lanes("reset", LANES_1, dptx_lnk_i.cfg_lanes);
        make_beats(1'b1);
        run_beats("reset", 1);                      // Only lane 0 after reset
        finish_test("reset");
    endtask

    task automatic test_pass();
        send_msg(MSG_ID_CTL, {5'd0, 1'b0, LANES_4});
        wait_cycles(PIPE);
        compare_lanes("pass", LANES_4, dptx_lnk_i.cfg_lanes);
        make_beats(1'b1);
        run_beats("pass", 4);
        finish_test("pass");
    endtask

    task automatic test_scramble();
        int i;
        send_msg(MSG_ID_CTL, {5'd0, 1'b1, LANES_4});
        wait_cycles(PIPE);
        make_beats(1'b1);
        for (int l = 0; l < LANES; l++)
        begin
            beat_dat[0][l*SPL*SYM_W +: SYM_W] = SYM_SR;     // SR first on each lane
            beat_k[0][l*SPL] = 1'b1;
        end
        for (int b = 0; b < BEATS; b++)
        begin
            for (int l = 0; l < LANES; l++)
            begin
                for (int s = 0; s < SPL; s++)
                begin
                    i = l*SPL + s;
                    exp_dat[b][i*SYM_W +: SYM_W] =
                        scramble_sym(l, beat_dat[b][i*SYM_W +: SYM_W], beat_k[b][i], 1'b1);
                    exp_k[b][i] = beat_k[b][i];
                end
            end
        end
        run_beats("scramble", 4);
        finish_test("scramble");
    endtask

    task automatic test_tps1();
        send_msg(MSG_ID_TPS, {6'd0, TPS1});
        wait_cycles(PIPE);
        compare_tps("tps1", TPS1, dptx_lnk_i.cfg_tps);
        repeat (16)
        begin
            @(negedge lnk_clk);
            for (int i = 0; i < NSYM; i++)
                compare_sym("tps1", i / SPL, i % SPL, SYM_D10_2, 1'b0,
                            lnk_dat[i*SYM_W +: SYM_W], lnk_k[i]);
        end
        finish_test("tps1");
    endtask

    // TPS1 runs before, so the first K28.5 on a lane starts the sequence
    task automatic test_tps2();
        logic [SYM_W:0] stream [LANES][COLLECT*SPL];
        logic [SYM_W:0] exp_sym;
        int             first;
        send_msg(MSG_ID_TPS, {6'd0, TPS2});
        for (int c = 0; c < COLLECT; c++)
        begin
            @(negedge lnk_clk);
            for (int i = 0; i < NSYM; i++)
                stream[i / SPL][c*SPL + i % SPL] = {lnk_k[i], lnk_dat[i*SYM_W +: SYM_W]};
        end
        compare_tps("tps2", TPS2, dptx_lnk_i.cfg_tps);
        for (int l = 0; l < LANES; l++)
        begin
            first = -1;
            for (int j = 0; j < COLLECT*SPL; j++)
                if (first < 0 && stream[l][j] == {1'b1, SYM_K28_5})
                    first = j;
            if (first < 0 || first > COLLECT*SPL - 2*TPS2_LEN)
            begin
                $display("lane %0d never started the TPS2 sequence in time", l);
                test_errs++;
            end
            else
            begin
                for (int j = first; j < COLLECT*SPL; j++)
                begin
                    exp_sym = tps2_expected(j - first);
                    compare_sym("tps2", l, j, exp_sym[SYM_W-1:0], exp_sym[SYM_W],
                                stream[l][j][SYM_W-1:0], stream[l][j][SYM_W]);
                end
            end
        end
        finish_test("tps2");
    endtask

    task automatic test_lanes();
        send_msg(MSG_ID_TPS, {6'd0, TPS_NONE});
        send_msg(MSG_ID_CTL, {5'd0, 1'b0, LANES_2});
        send_msg(8'h33, 8'h01);                     // Unknown ID, dropped
        wait_cycles(PIPE);
        compare_tps("lanes", TPS_NONE, dptx_lnk_i.cfg_tps);
        compare_lanes("lanes", LANES_2, dptx_lnk_i.cfg_lanes);
        make_beats(1'b1);
        run_beats("lanes", 2);
        finish_test("lanes");
    endtask

    initial
    begin
        void'($urandom(32'h7bd07c59));
        rst_n   = 1'b0;
        msg_vld = 1'b0;
        msg_som = 1'b0;
        msg_eom = 1'b0;
        msg_dat = '0;
        src_vld = 1'b0;
        src_dat = '0;
        src_k   = '0;
        for (int l = 0; l < LANES; l++)
            model_lfsr[l] = SCRM_SEED;
        repeat (10) @(posedge lnk_clk);
        rst_n <= 1'b1;
        @(posedge lnk_clk);
        test_reset();
        test_pass();
        test_scramble();
        test_tps1();
        test_tps2();
        test_lanes();
        $display("tests run %0d, failed %0d, mismatches %0d", tests_run, tests_failed, err_total);
        if (tests_failed == 0)
            $display(">>> PASS");
        else
            $display(">>> FAIL");
        $finish;
    end

    // Watchdog
    initial
    begin
        repeat (WD_CYC) @(posedge lnk_clk);
        $display("Watchdog expired after %0d cycles, the tests did not complete", WD_CYC);
        $display(">>> FAIL");
        $finish;
    end

endmodule

// File: dptx_lnk.f
+incdir+.
dptx_pkg.sv
dptx_msg_dec.sv
dptx_scrm.sv
dptx_trn.sv
dptx_skew.sv
dptx_lnk.sv
tb_dptx_lnk.sv

// File: Makefile
# Verilator build and run for the DisplayPort TX link testbench
# make compile, make run, make clean

TOP = tb_dptx_lnk

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert --top-module $(TOP) -f dptx_lnk.f -o $(TOP)

# Pass only when the log holds the pass line
run: compile
	./obj_dir/$(TOP) | tee sim.log
	grep -q '^>>> PASS$$' sim.log

clean:
	rm -rf obj_dir sim.log
